//--- common/dma_pkg.sv
/*
 * Shared types and constants of the DMA initiator request side.
 * Holds the descriptor layout, the NoC flit format and the tile setup.
 * Compile before every module that imports it.
 */
`default_nettype none

package dma_pkg;

  ////////////////////////////////////////
  // Sizes and tile setup
  ////////////////////////////////////////

  localparam int TABLE_ENTRIES   = 4;
  localparam int TABLE_PTR_W     = 2;
  localparam int NOC_PACKET_SIZE = 16;
  // Data flits left in a packet after header and address flit
  localparam int PKT_WORDS_MAX   = NOC_PACKET_SIZE - 2;
  localparam int PKT_CNT_W       = $clog2(NOC_PACKET_SIZE);
  localparam int SIZE_W          = 12;
  localparam int ADDR_W          = 32;
  localparam int DATA_W          = 32;

  // Identifier of this tile on the NoC
  localparam logic [4:0] TILE_ID = 5'd3;

  ////////////////////////////////////////
  // Codes
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    PAYLOAD = 2'b00,
    HEADER  = 2'b01,
    LAST    = 2'b10
  } flit_kind_e;

  typedef enum logic [1:0] {
    L2R_REQ = 2'b00,
    R2L_REQ = 2'b01
  } pkt_type_e;

  localparam logic [2:0] PKT_CLASS_DMA = 3'b010;

  ////////////////////////////////////////
  // Descriptor and flit layout
  ////////////////////////////////////////

  // Transfer descriptor, dir set means local to remote
  typedef struct packed {
    logic              dir;
    logic [ADDR_W-1:0] laddr;
    logic [ADDR_W-1:0] raddr;
    logic [4:0]        rtile;
    logic [SIZE_W-1:0] size;
  } dma_req_t;

  // Body of a header flit
  typedef struct packed {
    logic [4:0]        dest;
    logic [2:0]        pkt_class;
    pkt_type_e         pkt_type;
    logic [4:0]        source;
    logic [3:0]        pkt_id;
    logic              req_last;
    logic [SIZE_W-1:0] size;
  } flit_hdr_t;

  // Same 32 bits seen as header fields or as a payload word
  typedef union packed {
    flit_hdr_t         hdr;
    logic [DATA_W-1:0] word;
  } flit_body_u;

  typedef struct packed {
    flit_kind_e kind;
    flit_body_u body;
  } flit_t;

endpackage

`default_nettype wire

//--- src/dma_arb_rr.sv
/*
 * Round-robin arbiter over the request table entries.
 * Purely combinational; the caller registers nxt_gnt as the new grant.
 */
`timescale 1ns/1ps
`default_nettype none

module dma_arb_rr (
  input  wire logic [dma_pkg::TABLE_ENTRIES-1:0] req,
  input  wire logic [dma_pkg::TABLE_ENTRIES-1:0] gnt,
  output logic      [dma_pkg::TABLE_ENTRIES-1:0] nxt_gnt
);
  import dma_pkg::*;

  // Index of the current grant
  logic [TABLE_PTR_W-1:0] cur;
  // Candidate index in the search
  logic [TABLE_PTR_W-1:0] idx;
  logic                   found;

  always_comb begin
    // No grant yet, so the search starts at entry 0
    cur = TABLE_PTR_W'(TABLE_ENTRIES - 1);
    for (int i = 0; i < TABLE_ENTRIES; i++) begin
      if (gnt[i]) begin
        cur = TABLE_PTR_W'(i);
      end
    end

    // Hold the grant unless someone asks
    nxt_gnt = gnt;
    found   = 1'b0;
    idx     = cur;
    // Walk from the entry after the grant, the index wraps by width
    for (int k = 1; k <= TABLE_ENTRIES; k++) begin
      idx = cur + TABLE_PTR_W'(k);
      if (!found && req[idx]) begin
        nxt_gnt      = '0;
        nxt_gnt[idx] = 1'b1;
        found        = 1'b1;
      end
    end

    a_nxt_gnt_onehot: assert ($onehot0(nxt_gnt))
      else $error("arbiter grant is not one-hot");
  end

endmodule

`default_nettype wire

//--- src/dma_request_table.sv
/*
 * Request table holding host-written DMA descriptors and their valid bits.
 * The host writes by index, the generator reads by index, and the
 * response side clears an entry through the done strobe.
 */
`timescale 1ns/1ps
`default_nettype none

module dma_request_table (
  input  wire logic                                clk,
  input  wire logic                                rst,
  // Host write port
  input  wire logic                                wr_en,
  input  wire logic [dma_pkg::TABLE_PTR_W-1:0]     wr_pos,
  input  wire dma_pkg::dma_req_t                   wr_req,
  // Done strobe from response side
  input  wire logic                                done_en,
  input  wire logic [dma_pkg::TABLE_PTR_W-1:0]     done_pos,
  // Read port to generator
  input  wire logic [dma_pkg::TABLE_PTR_W-1:0]     rd_pos,
  output dma_pkg::dma_req_t                        rd_req,
  output logic      [dma_pkg::TABLE_ENTRIES-1:0]   valid
);
  import dma_pkg::*;

  // Descriptor storage
  dma_req_t entries [TABLE_ENTRIES];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      entries[wr_pos] <= wr_req;
    end
  end

  // Valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else begin
      // Done first, a write to the same entry wins
      if (done_en) begin
        valid[done_pos] <= 1'b0;
      end
      if (wr_en) begin
        valid[wr_pos] <= 1'b1;
      end
    end
  end

  // Combinational read
  assign rd_req = entries[rd_pos];

  // Host may only overwrite a free entry or one being retired now
  a_no_overwrite: assert property (@(posedge clk) disable iff (rst)
    wr_en |-> !valid[wr_pos] || (done_en && (done_pos == wr_pos)))
    else $error("write to a valid table entry");

endmodule

`default_nettype wire

//--- dma_nocreq/dma_local_reader.sv
/*
 * Local-memory read sequencer for L2R transfers. Issues word reads from
 * laddr on a start pulse and queues the data in a two-word buffer
 * that the generator drains through data_valid/data_ready.
 */
`timescale 1ns/1ps
`default_nettype none

module dma_local_reader (
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire logic                       start,
  input  wire logic [dma_pkg::ADDR_W-1:0] laddr,
  input  wire logic [dma_pkg::SIZE_W-1:0] size,
  input  wire logic                       is_l2r,
  // Memory port
  output logic                            mem_rd,
  output logic      [dma_pkg::ADDR_W-1:0] mem_addr,
  input  wire logic [dma_pkg::DATA_W-1:0] mem_rdata,
  // Words to the generator
  output logic      [dma_pkg::DATA_W-1:0] data,
  output logic                            data_valid,
  input  wire logic                       data_ready
);
  import dma_pkg::*;

  // Words still to read
  logic [SIZE_W-1:0] remaining;
  logic [ADDR_W-1:0] addr;
  // Read issued last cycle, data on mem_rdata now
  logic              pend;
  logic [DATA_W-1:0] fifo_q [2];
  logic              wr_ptr;
  logic              rd_ptr;
  logic [1:0]        count;
  logic              pop;
  // Slots used or promised once this cycle's pop is done
  logic [2:0]        committed;

  assign pop        = data_valid & data_ready;
  assign committed  = {1'b0, count} + {2'b00, pend} - {2'b00, pop};
  assign mem_rd     = (remaining != '0) && (committed < 3'd2);
  assign mem_addr   = addr;
  assign data       = fifo_q[rd_ptr];
  assign data_valid = (count != 2'd0);

  always_ff @(posedge clk) begin
    if (rst) begin
      remaining <= '0;
      pend      <= 1'b0;
      wr_ptr    <= 1'b0;
      rd_ptr    <= 1'b0;
      count     <= 2'd0;
    end else begin
      pend <= mem_rd;
      if (start && is_l2r) begin
        remaining <= size;
      end else if (mem_rd) begin
        remaining <= remaining - 1'b1;
      end
      if (pend) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      count <= count + {1'b0, pend} - {1'b0, pop};
    end
  end

  // Address and buffer payload
  always_ff @(posedge clk) begin
    if (start && is_l2r) begin
      addr <= laddr;
    end else if (mem_rd) begin
      addr <= addr + ADDR_W'(4);
    end
    if (pend) begin
      fifo_q[wr_ptr] <= mem_rdata;
    end
  end

  // A returning read always finds a free slot
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    pend |-> (count != 2'd2) || pop)
    else $error("read buffer overflow");

endmodule

`default_nettype wire

//--- dma_nocreq/dma_nocreq.sv
/*
 * Request packet generator. Picks a pending table entry round-robin,
 * emits its L2R data packets or R2L read request onto the NoC, and
 * keeps the entry open until the response side reports it done.
 */
`timescale 1ns/1ps
`default_nettype none

module dma_nocreq (
  input  wire logic                              clk,
  input  wire logic                              rst,
  // NoC output
  output dma_pkg::flit_t                         noc_out_flit,
  output logic                                   noc_out_valid,
  input  wire logic                              noc_out_ready,
  // Table read port
  output logic      [dma_pkg::TABLE_PTR_W-1:0]   rd_pos,
  input  wire dma_pkg::dma_req_t                 rd_req,
  input  wire logic [dma_pkg::TABLE_ENTRIES-1:0] valid,
  // Done strobe
  input  wire logic                              done_en,
  input  wire logic [dma_pkg::TABLE_PTR_W-1:0]   done_pos,
  // Local reader
  output logic                                   start,
  input  wire logic [dma_pkg::DATA_W-1:0]        data,
  input  wire logic                              data_valid,
  output logic                                   data_ready
);
  import dma_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_L2R_HDR,
    ST_L2R_ADDR,
    ST_L2R_DATA,
    ST_R2L_HDR,
    ST_R2L_SIZE,
    ST_R2L_RADDR,
    ST_R2L_LADDR
  } state_e;

  state_e state;
  state_e nxt_state;

  // Words sent in earlier packets of this request
  logic [SIZE_W-1:0]    req_cnt;
  logic [SIZE_W-1:0]    nxt_req_cnt;
  // Number of the current data flit in the packet, from 1
  logic [PKT_CNT_W-1:0] pkt_cnt;
  logic [PKT_CNT_W-1:0] nxt_pkt_cnt;
  // Data flits in the current packet
  logic [PKT_CNT_W-1:0] pkt_size;
  logic [PKT_CNT_W-1:0] nxt_pkt_size;

  // Arbiter grant, one-hot
  logic [TABLE_ENTRIES-1:0] select;
  logic [TABLE_ENTRIES-1:0] nxt_select;
  logic [TABLE_ENTRIES-1:0] requests;

  // Entries sent and waiting for their response
  logic [TABLE_ENTRIES-1:0] open_resp;
  logic [TABLE_ENTRIES-1:0] nxt_open_resp;

  logic                 nxt_start;
  logic [SIZE_W-1:0]    words_left;
  logic                 last_pkt;
  logic [PKT_CNT_W-1:0] pkt_words;
  flit_hdr_t            hdr;

  ////////////////////////////////////////
  // Entry selection
  ////////////////////////////////////////

  // Grant frozen while busy or while the start pulse is out
  assign requests = valid & ~open_resp & {TABLE_ENTRIES{(state == ST_IDLE) && !start}};

  dma_arb_rr u_arb (
    .req     (requests),
    .gnt     (select),
    .nxt_gnt (nxt_select)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      select <= '0;
    end else begin
      select <= nxt_select;
    end
  end

  // One-hot grant to table index
  always_comb begin
    rd_pos = '0;
    for (int i = 0; i < TABLE_ENTRIES; i++) begin
      if (select[i]) begin
        rd_pos = rd_pos | TABLE_PTR_W'(i);
      end
    end
  end

  // Single pulse per transfer
  assign nxt_start = (|(valid & ~open_resp)) && (state == ST_IDLE) && !start;

  ////////////////////////////////////////
  // Packet generation
  ////////////////////////////////////////

  // Split of an L2R request into packets
  assign words_left = rd_req.size - req_cnt;
  assign last_pkt   = (words_left <= SIZE_W'(PKT_WORDS_MAX));
  assign pkt_words  = last_pkt ? PKT_CNT_W'(words_left) : PKT_CNT_W'(PKT_WORDS_MAX);

  always_comb begin
    noc_out_valid = 1'b0;
    noc_out_flit  = '0;
    data_ready    = 1'b0;
    nxt_state     = state;
    nxt_req_cnt   = req_cnt;
    nxt_pkt_cnt   = pkt_cnt;
    nxt_pkt_size  = pkt_size;
    nxt_open_resp = open_resp;

    // Header fields shared by both request types
    hdr           = '0;
    hdr.dest      = rd_req.rtile;
    hdr.pkt_class = PKT_CLASS_DMA;
    hdr.source    = TILE_ID;
    hdr.pkt_id    = 4'(rd_pos);

    case (state)
      ST_IDLE: begin
        nxt_req_cnt = '0;
        if (start) begin
          nxt_state = rd_req.dir ? ST_L2R_HDR : ST_R2L_HDR;
        end
      end
      ST_L2R_HDR: begin
        noc_out_valid         = 1'b1;
        hdr.pkt_type          = L2R_REQ;
        hdr.req_last          = last_pkt;
        hdr.size              = SIZE_W'(pkt_words);
        noc_out_flit.kind     = HEADER;
        noc_out_flit.body.hdr = hdr;
        nxt_pkt_size          = pkt_words;
        nxt_pkt_cnt           = PKT_CNT_W'(1);
        if (noc_out_ready) begin
          nxt_state = ST_L2R_ADDR;
        end
      end
      ST_L2R_ADDR: begin
        noc_out_valid          = 1'b1;
        noc_out_flit.kind      = PAYLOAD;
        // Remote address advances by the words already sent
        noc_out_flit.body.word = rd_req.raddr + (ADDR_W'(req_cnt) << 2);
        if (noc_out_ready) begin
          nxt_state = ST_L2R_DATA;
        end
      end
      ST_L2R_DATA: begin
        // Forward reader words as they come
        noc_out_valid          = data_valid;
        noc_out_flit.body.word = data;
        if (pkt_cnt == pkt_size) begin
          noc_out_flit.kind = LAST;
        end else begin
          noc_out_flit.kind = PAYLOAD;
        end
        if (noc_out_ready && data_valid) begin
          data_ready  = 1'b1;
          nxt_pkt_cnt = pkt_cnt + 1'b1;
          if (pkt_cnt == pkt_size) begin
            nxt_req_cnt = req_cnt + SIZE_W'(pkt_cnt);
            if (last_pkt) begin
              // Request complete, wait for the response
              nxt_open_resp = open_resp | select;
              nxt_state     = ST_IDLE;
            end else begin
              nxt_state = ST_L2R_HDR;
            end
          end
        end
      end
      ST_R2L_HDR: begin
        noc_out_valid         = 1'b1;
        hdr.pkt_type          = R2L_REQ;
        hdr.req_last          = 1'b1;
        noc_out_flit.kind     = HEADER;
        noc_out_flit.body.hdr = hdr;
        if (noc_out_ready) begin
          nxt_state = ST_R2L_SIZE;
        end
      end
      ST_R2L_SIZE: begin
        noc_out_valid          = 1'b1;
        noc_out_flit.kind      = PAYLOAD;
        noc_out_flit.body.word = DATA_W'(rd_req.size);
        if (noc_out_ready) begin
          nxt_state = ST_R2L_RADDR;
        end
      end
      ST_R2L_RADDR: begin
        noc_out_valid          = 1'b1;
        noc_out_flit.kind      = PAYLOAD;
        noc_out_flit.body.word = rd_req.raddr;
        if (noc_out_ready) begin
          nxt_state = ST_R2L_LADDR;
        end
      end
      ST_R2L_LADDR: begin
        noc_out_valid          = 1'b1;
        noc_out_flit.kind      = LAST;
        noc_out_flit.body.word = rd_req.laddr;
        if (noc_out_ready) begin
          nxt_open_resp = open_resp | select;
          nxt_state     = ST_IDLE;
        end
      end
      default: begin
        nxt_state = ST_IDLE;
      end
    endcase

    // Response side retires the entry
    if (done_en) begin
      nxt_open_resp[done_pos] = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ST_IDLE;
      req_cnt   <= '0;
      pkt_cnt   <= '0;
      pkt_size  <= '0;
      open_resp <= '0;
      start     <= 1'b0;
    end else begin
      state     <= nxt_state;
      req_cnt   <= nxt_req_cnt;
      pkt_cnt   <= nxt_pkt_cnt;
      pkt_size  <= nxt_pkt_size;
      open_resp <= nxt_open_resp;
      start     <= nxt_start;
    end
  end

  // Flit held under back-pressure, table and reader included
  a_flit_stable: assert property (@(posedge clk) disable iff (rst)
    noc_out_valid && !noc_out_ready |=> noc_out_valid && $stable(noc_out_flit))
    else $error("NoC flit changed while stalled");

endmodule

`default_nettype wire

//--- src/dma_initiator.sv
/*
 * Top of the DMA initiator request side.
 * Joins request table, packet generator and local reader.
 */
`timescale 1ns/1ps
`default_nettype none

module dma_initiator (
  input  wire logic                              clk,
  input  wire logic                              rst,
  // Host write port
  input  wire logic                              wr_en,
  input  wire logic [dma_pkg::TABLE_PTR_W-1:0]   wr_pos,
  input  wire dma_pkg::dma_req_t                 wr_req,
  // Done strobe
  input  wire logic                              done_en,
  input  wire logic [dma_pkg::TABLE_PTR_W-1:0]   done_pos,
  // NoC output
  output dma_pkg::flit_t                         noc_out_flit,
  output logic                                   noc_out_valid,
  input  wire logic                              noc_out_ready,
  // Local memory
  output logic                                   mem_rd,
  output logic      [dma_pkg::ADDR_W-1:0]        mem_addr,
  input  wire logic [dma_pkg::DATA_W-1:0]        mem_rdata
);
  import dma_pkg::*;

  logic [TABLE_PTR_W-1:0]   rd_pos;
  dma_req_t                 rd_req;
  logic [TABLE_ENTRIES-1:0] valid;
  logic                     start;
  logic [DATA_W-1:0]        data;
  logic                     data_valid;
  logic                     data_ready;

  dma_request_table u_table (
    .clk      (clk),
    .rst      (rst),
    .wr_en    (wr_en),
    .wr_pos   (wr_pos),
    .wr_req   (wr_req),
    .done_en  (done_en),
    .done_pos (done_pos),
    .rd_pos   (rd_pos),
    .rd_req   (rd_req),
    .valid    (valid)
  );

  dma_nocreq u_nocreq (
    .clk           (clk),
    .rst           (rst),
    .noc_out_flit  (noc_out_flit),
    .noc_out_valid (noc_out_valid),
    .noc_out_ready (noc_out_ready),
    .rd_pos        (rd_pos),
    .rd_req        (rd_req),
    .valid         (valid),
    .done_en       (done_en),
    .done_pos      (done_pos),
    .start         (start),
    .data          (data),
    .data_valid    (data_valid),
    .data_ready    (data_ready)
  );

  // Reader takes its transfer fields straight from the selected descriptor
  dma_local_reader u_reader (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .laddr      (rd_req.laddr),
    .size       (rd_req.size),
    .is_l2r     (rd_req.dir),
    .mem_rd     (mem_rd),
    .mem_addr   (mem_addr),
    .mem_rdata  (mem_rdata),
    .data       (data),
    .data_valid (data_valid),
    .data_ready (data_ready)
  );

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
/*
 * Free-running testbench clock, 10 ns period, low at time zero.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk
);

  initial begin
    clk = 1'b0;
    // Half period of 5 ns
    forever #5 clk = ~clk;
  end

endmodule

`default_nettype wire

//--- dv/dma_initiator_tb.sv
/*
 * Testbench of the DMA initiator request side.
 * Replays descriptor writes and done strobes from dv/dma_vectors.txt and
 * checks each accepted NoC flit against the expected stream.
 */
`timescale 1ns/1ps
`default_nettype none

module dma_initiator_tb;
  import dma_pkg::*;

  // Words per vector record and records the file may hold
  localparam int REC_W   = 8;
  localparam int REC_MAX = 40;
  // Memory model returns address XOR this key
  localparam logic [31:0] MEM_KEY = 32'hA5A5_0000;

  logic                   clk;
  logic                   rst;
  logic                   wr_en;
  logic [TABLE_PTR_W-1:0] wr_pos;
  dma_req_t               wr_req;
  logic                   done_en;
  logic [TABLE_PTR_W-1:0] done_pos;
  flit_t                  noc_out_flit;
  logic                   noc_out_valid;
  logic                   noc_out_ready;
  logic                   mem_rd;
  logic [ADDR_W-1:0]      mem_addr;
  logic [DATA_W-1:0]      mem_rdata;

  logic [31:0]       vec [REC_W*REC_MAX];
  integer            seed;
  int                errors;
  int                checks;
  int                cycles;
  int                cycle_limit;
  logic              rd_seen;
  logic [ADDR_W-1:0] addr_seen;

  tb_clock u_clock (
    .clk (clk)
  );

  dma_initiator UUT (
    .clk           (clk),
    .rst           (rst),
    .wr_en         (wr_en),
    .wr_pos        (wr_pos),
    .wr_req        (wr_req),
    .done_en       (done_en),
    .done_pos      (done_pos),
    .noc_out_flit  (noc_out_flit),
    .noc_out_valid (noc_out_valid),
    .noc_out_ready (noc_out_ready),
    .mem_rd        (mem_rd),
    .mem_addr      (mem_addr),
    .mem_rdata     (mem_rdata)
  );

  ////////////////////////////////////////
  // Environment models
  ////////////////////////////////////////

  // Memory answers one cycle after each read without stalling
  always begin
    @(negedge clk);
    rd_seen   = mem_rd;
    addr_seen = mem_addr;
    @(posedge clk);
    #1;
    mem_rdata = rd_seen ? (addr_seen ^ MEM_KEY) : 32'h0;
  end

  // NoC ready about 70 percent of cycles
  always begin
    @(posedge clk);
    #1;
    noc_out_ready = ($unsigned($random(seed)) % 100) < 70;
  end

  // Run limit from the expected flit count
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, expected flits did not all arrive", cycles);
      $display("Checks run %0d, errors %0d", checks, errors);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Tasks
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Returns the flit that the NoC takes at the next rising edge
  task automatic take_flit(output flit_t f);
    @(negedge clk);
    while (!(noc_out_valid && noc_out_ready)) begin
      @(negedge clk);
    end
    f = noc_out_flit;
  endtask

  task automatic write_entry(input logic [31:0] pos, input logic [31:0] dir,
                             input logic [31:0] laddr, input logic [31:0] raddr,
                             input logic [31:0] rtile, input logic [31:0] size);
    wr_en        = 1'b1;
    wr_pos       = pos[TABLE_PTR_W-1:0];
    wr_req.dir   = dir[0];
    wr_req.laddr = laddr;
    wr_req.raddr = raddr;
    wr_req.rtile = rtile[4:0];
    wr_req.size  = size[SIZE_W-1:0];
  endtask

  // One L2R packet as header and address flit then data words
  task automatic expect_l2r(input logic [31:0] hdr, input logic [31:0] addr,
                            input int count, input logic [31:0] laddr);
    flit_t       f;
    logic [31:0] word;
    take_flit(f);
    check_value("header kind", 32'(f.kind), 32'(HEADER));
    check_value("header flit", f.body.word, hdr);
    take_flit(f);
    check_value("address kind", 32'(f.kind), 32'(PAYLOAD));
    check_value("address flit", f.body.word, addr);
    for (int i = 0; i < count; i++) begin
      word = (laddr + 32'(4 * i)) ^ MEM_KEY;
      take_flit(f);
      // Final word of the packet closes it
      check_value("data kind", 32'(f.kind), (i == count - 1) ? 32'(LAST) : 32'(PAYLOAD));
      check_value("data flit", f.body.word, word);
    end
  endtask

  // R2L read request of four flits
  task automatic expect_r2l(input logic [31:0] hdr, input logic [31:0] size,
                            input logic [31:0] raddr, input logic [31:0] laddr);
    flit_t f;
    take_flit(f);
    check_value("request header kind", 32'(f.kind), 32'(HEADER));
    check_value("request header flit", f.body.word, hdr);
    take_flit(f);
    check_value("size kind", 32'(f.kind), 32'(PAYLOAD));
    check_value("size flit", f.body.word, size);
    take_flit(f);
    check_value("raddr kind", 32'(f.kind), 32'(PAYLOAD));
    check_value("raddr flit", f.body.word, raddr);
    take_flit(f);
    check_value("laddr kind", 32'(f.kind), 32'(LAST));
    check_value("laddr flit", f.body.word, laddr);
  endtask

  // No flit and no memory read for n cycles
  task automatic stay_quiet(input int n);
    repeat (n) begin
      @(negedge clk);
      check_value("noc_out_valid", 32'(noc_out_valid), 32'd0);
      check_value("mem_rd", 32'(mem_rd), 32'd0);
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int          flits;
    int          rec;
    int          b;
    logic [31:0] op;
    rst           = 1'b1;
    wr_en         = 1'b0;
    wr_pos        = '0;
    wr_req        = '0;
    done_en       = 1'b0;
    done_pos      = '0;
    noc_out_ready = 1'b0;
    mem_rdata     = '0;
    seed          = 32'h31d1;
    errors        = 0;
    checks        = 0;
    cycles        = 0;

    $readmemh("dv/dma_vectors.txt", vec);
    // Header and address flit per packet plus its data words
    flits = 0;
    for (int r = 0; r < REC_MAX; r++) begin
      if (vec[r*REC_W] == 32'd2) begin
        flits = flits + 2 + int'(vec[r*REC_W+3]);
      end else if (vec[r*REC_W] == 32'd3) begin
        flits = flits + 4;
      end
    end
    cycle_limit = 4 * flits + 200;
    if (flits == 0) begin
      errors++;
      $display("Vector file holds no expected flits");
    end

    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    rec = 0;
    op  = vec[0];
    while (op != 32'd0 && rec < REC_MAX) begin
      b = rec * REC_W;
      // Each record starts 1 ns after an edge with strobes released
      @(posedge clk);
      #1;
      wr_en   = 1'b0;
      done_en = 1'b0;
      case (op)
        32'd1: write_entry(vec[b+1], vec[b+2], vec[b+3], vec[b+4], vec[b+5], vec[b+6]);
        32'd2: expect_l2r(vec[b+1], vec[b+2], int'(vec[b+3]), vec[b+4]);
        32'd3: expect_r2l(vec[b+1], vec[b+2], vec[b+3], vec[b+4]);
        32'd4: begin
          done_en  = 1'b1;
          done_pos = vec[b+1][TABLE_PTR_W-1:0];
        end
        32'd5: stay_quiet(int'(vec[b+1]));
        default: begin
          errors++;
          $display("Unknown record type %0h at record %0d of the vector file", op, rec);
        end
      endcase
      rec++;
      op = vec[rec*REC_W];
    end

    @(posedge clk);
    #1;
    wr_en   = 1'b0;
    done_en = 1'b0;
    repeat (2) @(posedge clk);

    $display("Checks run %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dma_initiator.f
common/dma_pkg.sv
src/dma_arb_rr.sv
src/dma_request_table.sv
dma_nocreq/dma_local_reader.sv
dma_nocreq/dma_nocreq.sv
src/dma_initiator.sv
dv/tb_clock.sv
dv/dma_initiator_tb.sv

//--- Makefile
TOP = dma_initiator_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f dma_initiator.f \
	  --top-module $(TOP) --Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^TESTBENCH PASSED" sim.log

lint:
	verilator --lint-only -Wall common/dma_pkg.sv src/dma_arb_rr.sv \
	  src/dma_request_table.sv dma_nocreq/dma_local_reader.sv \
	  dma_nocreq/dma_nocreq.sv src/dma_initiator.sv --top-module dma_initiator

clean:
	rm -rf obj_dir sim.log

//--- dv/dma_vectors.txt
// op 1 write: entry dir laddr raddr rtile size | op 2 L2R packet: header addr words laddr
// op 3 R2L request: header size raddr laddr | op 4 done: entry | op 5 quiet: cycles | op 0 end
5 0000000a 0 0 0 0 0 0
1 0 1 00001000 40000000 05 005 0
2 2a061005 40000000 5 00001000 0 0 0
4 0 0 0 0 0 0 0
1 1 1 00002000 50000100 09 01e 0
2 4a06200e 50000100 e 00002000 0 0 0
2 4a06200e 50000138 e 00002038 0 0 0
2 4a063002 50000170 2 00002070 0 0 0
4 1 0 0 0 0 0 0
1 2 0 00003000 60000200 0c 010 0
3 62465000 00000010 60000200 00003000 0 0 0
5 4 0 0 0 0 0 0
4 2 0 0 0 0 0 0
1 1 1 00004000 70000000 07 003 0
1 3 0 00005000 71000000 01 020 0
1 0 1 00006000 72000040 05 002 0
2 3a063003 70000000 3 00004000 0 0 0
3 0a467000 00000020 71000000 00005000 0 0 0
2 2a061002 72000040 2 00006000 0 0 0
5 8 0 0 0 0 0 0
4 3 0 0 0 0 0 0
1 3 1 00007000 73000000 01 004 0
2 0a067004 73000000 4 00007000 0 0 0
4 1 0 0 0 0 0 0
4 0 0 0 0 0 0 0
4 3 0 0 0 0 0 0
0 0 0 0 0 0 0 0
